//--- filelist.f
hw/sdram_pkg.sv
hw/port_select.sv
hw/sdram_sequencer.sv
hw/read_return.sv
hw/sdram_ctrl_top.sv
bench/sdram_model.sv
bench/tb_sdram_ctrl.sv

//--- run_sim.sh
#!/bin/sh
# build and run the SDRAM controller testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 -f filelist.f \
	--top-module tb_sdram_ctrl -o tb_sdram_ctrl

# the pipe keeps set -e from stopping before the log is searched
./obj_dir/tb_sdram_ctrl 2>&1 | tee sim.log

if grep -qF '*** TEST FAILED ***' sim.log; then
	echo "simulation failed, see sim.log"
	exit 1
fi
if ! grep -qF '*** TEST PASSED ***' sim.log; then
	echo "simulation ended without a result, see sim.log"
	exit 1
fi
echo "simulation passed"

//--- bench/tb_sdram_ctrl.sv
// port1 and fetches use a 4-row by 8-column window in banks 0/1, port2 the same in banks 2/3; reads use full masks
`timescale 1ns/1ps

module tb_sdram_ctrl;
	import sdram_pkg::*;

	// ----------------------------------------
	// run length
	// ----------------------------------------
	localparam int n_preload = 64;   // every word of one bank pair's window
	localparam int n_port1   = 150;
	localparam int n_both    = 100;
	localparam int n_mixed   = 100;
	localparam int n_fetch   = 40;
	localparam int n_ops     = 2 * n_preload + n_port1 + 2 * n_both + n_mixed + 2 * n_fetch;
	localparam int powerup_cycles = 3 + 6 * init_count;

	logic        clk;
	logic        init_n;
	logic        port1_req;
	logic        port1_we;
	logic [23:1] port1_a;
	logic [1:0]  port1_ds;
	logic [15:0] port1_d;
	logic        port1_ack;
	logic [15:0] port1_q;
	logic        port2_req;
	logic        port2_we;
	logic [23:1] port2_a;
	logic [1:0]  port2_ds;
	logic [15:0] port2_d;
	logic        port2_ack;
	logic [15:0] port2_q;
	logic [15:1] cpu1_addr;
	logic [15:1] cpu2_addr;
	logic [15:0] cpu1_q;
	logic [15:0] cpu2_q;
	wire  [15:0] sdram_dq;
	logic [12:0] sdram_a;
	logic [1:0]  sdram_ba;
	logic        sdram_dqml;
	logic        sdram_dqmh;
	logic        sdram_ncs;
	logic        sdram_nras;
	logic        sdram_ncas;
	logic        sdram_nwe;
	logic        check_gap;
	logic        init_done;
	logic        fault;

	int          seed;
	logic [15:0] ref_mem [128];   // reference memory, {bank, row, col}
	logic [15:0] last_fetch [2];  // word last seen on cpu1_q / cpu2_q

	sdram_ctrl_top i_sdram_ctrl_top (.*);

	sdram_model i_sdram_model (
		.clk, .init_n, .dq(sdram_dq), .a(sdram_a), .ba(sdram_ba),
		.dqml(sdram_dqml), .dqmh(sdram_dqmh), .ncs(sdram_ncs), .nras(sdram_nras),
		.ncas(sdram_ncas), .nwe(sdram_nwe), .check_gap, .init_done, .fault
	);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;  // 125 MHz
	end

	initial begin
		repeat (n_ops * 60 + powerup_cycles) @(posedge clk);
		abort_run("watchdog expired before all operations finished");
	end

	always @(negedge clk)
		if (fault)
			abort_run("chip model reported a protocol fault");

	// ----------------------------------------
	// checks
	// ----------------------------------------
	task automatic abort_run(input string why);
		$display("%s", why);
		$display("*** TEST FAILED ***");
		$fatal(1);
	endtask

	task automatic check_word(input string name, input logic [15:0] exp, input logic [15:0] act);
		if (act !== exp)
			abort_run($sformatf("[ERROR] %s: expected %h, actual %h", name, exp, act));
	endtask

	task automatic check_ack(input string name, input logic exp, input logic act);
		if (act !== exp)
			abort_run($sformatf("[ERROR] %s: expected %b, actual %b", name, exp, act));
	endtask

	function automatic logic [6:0] word_index(input logic [1:0] bank, input logic [1:0] row,
		input logic [2:0] col);
		return {bank, row, col};
	endfunction

	// bank bit 23, row 22:10, column 9:1
	function automatic logic [23:1] port_addr(input logic b, input logic [1:0] row,
		input logic [2:0] col);
		return {b, 11'd0, row, 6'd0, col};
	endfunction

	function automatic logic [15:0] merge_bytes(input logic [15:0] old, input logic [15:0] d,
		input logic [1:0] ds);
		return {ds[1] ? d[15:8] : old[15:8], ds[0] ? d[7:0] : old[7:0]};
	endfunction

	// ----------------------------------------
	// stimulus
	// ----------------------------------------
	task automatic port_access(input logic p2, input logic we, input logic b,
		input logic [1:0] row, input logic [2:0] col, input logic [1:0] ds, input logic [15:0] d);
		logic [6:0]  k;
		logic [15:0] exp;
		k   = word_index({p2, b}, row, col);
		exp = ref_mem[k];
		@(negedge clk);
		if (p2) begin
			port2_we  = we;
			port2_a   = port_addr(b, row, col);
			port2_ds  = ds;
			port2_d   = d;
			port2_req = ~port2_req;
		end else begin
			port1_we  = we;
			port1_a   = port_addr(b, row, col);
			port1_ds  = ds;
			port1_d   = d;
			port1_req = ~port1_req;
		end
		if (we)
			ref_mem[k] = merge_bytes(ref_mem[k], d, ds);
		do
			@(negedge clk);
		while (p2 ? (port2_ack != port2_req) : (port1_ack != port1_req));
		if (!we)
			check_word(p2 ? "port2 read" : "port1 read", exp, p2 ? port2_q : port1_q);
	endtask

	task automatic preload(input logic p2);
		logic [31:0] r;
		for (int i = 0; i < n_preload; i++) begin
			r = $random(seed);
			port_access(p2, 1'b1, i[5], i[4:3], i[2:0], 2'b11, r[15:0]);
		end
	endtask

	task automatic rand_access(input logic p2, input logic writes_bank1);
		logic [31:0] r;
		logic        we;
		logic        b;
		r  = $random(seed);
		we = r[0];
		b  = (writes_bank1 && we) ? 1'b1 : r[1];  // keeps writes off the fetch bank
		port_access(p2, we, b, r[3:2], r[6:4], we ? r[8:7] : 2'b11, r[31:16]);
		r = $random(seed);
		repeat (r[2:0]) @(negedge clk);
	endtask

	// the next word must differ from the last, so a change on q marks the end
	task automatic fetch_run(input logic which, input int n);
		logic [31:0] r;
		logic [6:0]  k;
		logic [15:0] exp;
		logic [15:1] next_a;
		repeat (n) begin
			do begin
				r      = $random(seed);
				k      = word_index(2'b00, r[1:0], r[4:2]);
				next_a = {4'd0, r[1:0], 6'd0, r[4:2]};
			end while (ref_mem[k] == last_fetch[which] ||
				next_a == (which ? cpu2_addr : cpu1_addr));  // same address fetches nothing
			exp = ref_mem[k];
			@(negedge clk);
			if (which)
				cpu2_addr = next_a;
			else
				cpu1_addr = next_a;
			do
				@(negedge clk);
			while ((which ? cpu2_q : cpu1_q) == last_fetch[which]);
			check_word(which ? "cpu2 fetch" : "cpu1 fetch", exp, which ? cpu2_q : cpu1_q);
			last_fetch[which] = exp;
			repeat (r[7:5]) @(negedge clk);
		end
	endtask

	initial begin
		seed = 32'h1335_6558;
		init_n    = 1'b0;
		port1_req = 1'b0;
		port1_we  = 1'b0;
		port1_a   = '0;
		port1_ds  = 2'b00;
		port1_d   = '0;
		port2_req = 1'b0;
		port2_we  = 1'b0;
		port2_a   = '0;
		port2_ds  = 2'b00;
		port2_d   = '0;
		cpu1_addr = '0;
		cpu2_addr = '0;
		check_gap = 1'b0;
		last_fetch[0] = '0;
		last_fetch[1] = '0;
		repeat (3) @(posedge clk);
		@(negedge clk);
		init_n = 1'b1;

		// outputs quiet after reset, then power-up order is watched by the model
		check_ack("port1 ack after reset", 1'b0, port1_ack);
		check_ack("port2 ack after reset", 1'b0, port2_ack);
		check_word("cpu1 data after reset", 16'h0000, cpu1_q);
		check_word("cpu2 data after reset", 16'h0000, cpu2_q);
		while (!init_done)
			@(negedge clk);

		// port1 alone, refresh gap watched
		preload(1'b0);
		check_gap = 1'b1;
		repeat (n_port1) begin
			rand_access(1'b0, 1'b0);
			check_ack("port2 idle", 1'b0, port2_ack);  // never requested yet
		end
		check_gap = 1'b0;

		// both bank pairs at once
		preload(1'b1);
		fork
			repeat (n_both) rand_access(1'b0, 1'b0);
			repeat (n_both) rand_access(1'b1, 1'b0);
		join

		// fetches on bank 0 next to port1 traffic
		fork
			repeat (n_mixed) rand_access(1'b0, 1'b1);
			fetch_run(1'b0, n_fetch);
			fetch_run(1'b1, n_fetch);
		join

		repeat (12) @(negedge clk);
		if (fault) begin
			$display("chip model reported a protocol fault at the end of the run");
			$display("*** TEST FAILED ***");
			$fatal(1);
		end else begin
			$display("*** TEST PASSED ***");
			$finish;
		end
	end

endmodule

//--- bench/sdram_model.sv
// behavioral x16 SDRAM for single-word CL2 access; read masks are ignored, unwritten words return an address-based fill
`timescale 1ns/1ps

module sdram_model (
	input  logic        clk,
	input  logic        init_n,
	inout  wire  [15:0] dq,
	input  logic [12:0] a,
	input  logic [1:0]  ba,
	input  logic        dqml,
	input  logic        dqmh,
	input  logic        ncs,
	input  logic        nras,
	input  logic        ncas,
	input  logic        nwe,
	input  logic        check_gap,  // refresh gap watched while high
	output logic        init_done,
	output logic        fault
);
	import sdram_pkg::*;

	logic [15:0] mem [logic [23:0]];  // sparse, keyed by {bank, row, column}
	logic [3:0]  cmd;
	sdram_a_t    addr;
	logic [2:0]  step;                // power-up progress, 4 = done
	logic [3:0]  open_bank;
	logic [12:0] open_row [4];
	int          act_cycle [4];
	int          cycle;
	int          last_ref;
	logic        rd_valid;            // first CL2 stage
	logic [15:0] rd_data;
	logic        out_en;              // second stage, on the pins
	logic [15:0] out_data;

	assign cmd       = {ncs, nras, ncas, nwe};
	assign addr      = a;
	assign init_done = (step == 3'd4);
	assign dq        = out_en ? out_data : 16'bz;

	function automatic logic [15:0] fill_word(input logic [23:0] k);
		return k[15:0] ^ {k[23:16], 8'h5a};
	endfunction

	task automatic report_fault(input string what);
		$display("sdram_model: %s (cycle %0d)", what, cycle);
		fault <= 1'b1;
	endtask

	always @(posedge clk or negedge init_n) begin
		if (!init_n) begin
			cycle     <= 0;
			last_ref  <= 0;
			step      <= 3'd0;
			open_bank <= 4'd0;
			rd_valid  <= 1'b0;
			rd_data   <= '0;
			out_en    <= 1'b0;  // bus released
			out_data  <= '0;
			fault     <= 1'b0;
		end else begin : run
			logic [23:0] key;
			logic [15:0] old;
			cycle    <= cycle + 1;
			out_en   <= rd_valid;  // sampled by the controller on the next edge
			out_data <= rd_data;
			rd_valid <= 1'b0;
			if (check_gap && cycle - last_ref > int'(refresh_period) + 200)
				report_fault("refresh gap longer than the period allows");
			key = {ba, open_row[ba], addr.col.column};

			// ----------------------------------------
			// power-up order
			// ----------------------------------------
			if (cmd != cmd_nop && !init_done) begin
				if (step == 3'd0 && cmd == cmd_precharge && addr.col.auto_pre)
					step <= 3'd1;                    // precharge all
				else if ((step == 3'd1 || step == 3'd2) && cmd == cmd_refresh) begin
					step     <= step + 3'd1;
					last_ref <= cycle;
				end else if (step == 3'd3 && cmd == cmd_load_mode && addr.mode == mode_word)
					step <= 3'd4;
				else
					report_fault("power-up sequence out of order or access before load mode");
			end else if (cmd != cmd_nop) begin
				case (cmd)
					cmd_active: begin
						if (open_bank[ba])
							report_fault("ACTIVE to a bank that is already open");
						open_bank[ba] <= 1'b1;
						open_row[ba]  <= addr.row;
						act_cycle[ba] <= cycle;
					end
					cmd_read, cmd_write: begin
						if (!open_bank[ba])
							report_fault("READ or WRITE to a bank with no open row");
						else if (cycle - act_cycle[ba] < 2)
							report_fault("READ or WRITE less than 2 cycles after ACTIVE");
						else begin
							if (cmd == cmd_read) begin
								rd_valid <= 1'b1;
								rd_data  <= mem.exists(key) ? mem[key] : fill_word(key);
							end else begin
								old      = mem.exists(key) ? mem[key] : fill_word(key);
								mem[key] = {dqmh ? old[15:8] : dq[15:8],
									dqml ? old[7:0] : dq[7:0]};  // dqm high keeps the byte
							end
							open_bank[ba] <= !addr.col.auto_pre;
						end
					end
					cmd_refresh: begin
						if (open_bank != 4'd0)
							report_fault("REFRESH while a bank is open");
						last_ref <= cycle;
					end
					default: report_fault("unexpected command after power-up");
				endcase
			end
		end
	end

endmodule

//--- hw/sdram_ctrl_top.sv
// one MT48LC16M16-class chip; port1 and fetches use banks 0/1, port2 uses banks 2/3
`timescale 1ns/1ps

module sdram_ctrl_top (
	input  logic        clk,
	input  logic        init_n,
	// chip pins
	inout  wire  [15:0] sdram_dq,
	output logic [12:0] sdram_a,
	output logic [1:0]  sdram_ba,
	output logic        sdram_dqml,
	output logic        sdram_dqmh,
	output logic        sdram_ncs,
	output logic        sdram_nras,
	output logic        sdram_ncas,
	output logic        sdram_nwe,
	// port1, banks 0/1
	input  logic        port1_req,
	output logic        port1_ack,
	input  logic        port1_we,
	input  logic [23:1] port1_a,
	input  logic [1:0]  port1_ds,
	input  logic [15:0] port1_d,
	output logic [15:0] port1_q,
	// read-only fetch ports
	input  logic [15:1] cpu1_addr,
	output logic [15:0] cpu1_q,
	input  logic [15:1] cpu2_addr,
	output logic [15:0] cpu2_q,
	// port2, banks 2/3
	input  logic        port2_req,
	output logic        port2_ack,
	input  logic        port2_we,
	input  logic [23:1] port2_a,
	input  logic [1:0]  port2_ds,
	input  logic [15:0] port2_d,
	output logic [15:0] port2_q
);
	import sdram_pkg::*;

	logic [1:0]  next_port0, next_port1;
	logic [24:1] next_addr0, next_addr1;
	logic        take0, take1, refresh_busy;
	logic [2:0]  slot;
	logic        rd_arm0, rd_arm1, wr_done0, wr_done1;
	logic [1:0]  rd_port0, rd_port1;
	logic [3:0]  cmd;
	sdram_a_t    sd_a;
	logic [1:0]  dqm;
	logic [15:0] dq_out;
	logic        dq_oe;

	// ----------------------------------------
	// pins
	// ----------------------------------------
	assign sdram_dq   = dq_oe ? dq_out : 16'bz;  // released except on write CAS
	assign sdram_a    = sd_a;
	assign {sdram_dqmh, sdram_dqml} = dqm;
	assign {sdram_ncs, sdram_nras, sdram_ncas, sdram_nwe} = cmd;

	port_select i_port_select (
		.clk, .init_n,
		.port1_req, .port1_a, .cpu1_addr, .cpu2_addr, .port2_req, .port2_a,
		.refresh_busy, .take0, .take1,
		.next_port0, .next_addr0, .next_port1, .next_addr1
	);

	sdram_sequencer i_sdram_sequencer (
		.clk, .init_n,
		.next_port0, .next_addr0, .next_port1, .next_addr1,
		.port1_we, .port1_ds, .port1_d, .port2_we, .port2_ds, .port2_d,
		.take0, .take1, .refresh_busy, .slot,
		.rd_arm0, .rd_port0, .rd_arm1, .rd_port1, .wr_done0, .wr_done1,
		.cmd, .sd_a, .sd_ba(sdram_ba), .dqm, .dq_out, .dq_oe
	);

	read_return i_read_return (
		.clk, .init_n, .slot,
		.dq_in(sdram_dq),  // bus read back, own writes included
		.rd_arm0, .rd_port0, .rd_arm1, .rd_port1, .wr_done0, .wr_done1,
		.port1_req, .port2_req,
		.port1_q, .port1_ack, .cpu1_q, .cpu2_q, .port2_q, .port2_ack
	);

endmodule

//--- hw/read_return.sv
// data is taken from the registered bus, so CL2 reads land one slot boundary after the CAS pair
`timescale 1ns/1ps

module read_return (
	input  logic        clk,
	input  logic        init_n,
	input  logic [2:0]  slot,
	input  logic [15:0] dq_in,
	input  logic        rd_arm0,    // slot 0 read in flight
	input  logic [1:0]  rd_port0,
	input  logic        rd_arm1,
	input  logic [1:0]  rd_port1,
	input  logic        wr_done0,
	input  logic        wr_done1,
	input  logic        port1_req,
	input  logic        port2_req,
	output logic [15:0] port1_q,
	output logic        port1_ack,
	output logic [15:0] cpu1_q,
	output logic [15:0] cpu2_q,
	output logic [15:0] port2_q,
	output logic        port2_ack
);
	import sdram_pkg::*;

	logic [15:0] sd_din;  // bus sampled every edge

	always_ff @(posedge clk) begin
		sd_din <= dq_in;
	end

	// ----------------------------------------
	// routing and acks
	// ----------------------------------------
	always_ff @(posedge clk or negedge init_n) begin
		if (!init_n) begin
			port1_q   <= '0;
			port1_ack <= 1'b0;
			cpu1_q    <= '0;
			cpu2_q    <= '0;
			port2_q   <= '0;
			port2_ack <= 1'b0;
		end else begin
			if (wr_done0)
				port1_ack <= port1_req;  // write acked at its CAS
			if (wr_done1)
				port2_ack <= port2_req;

			if (slot == slot_read0 && rd_arm0) begin
				case (rd_port0)
					port_req: begin
						port1_q   <= sd_din;
						port1_ack <= port1_req;  // data and ack together
					end
					port_cpu1: cpu1_q <= sd_din;
					port_cpu2: cpu2_q <= sd_din;
					default: ;
				endcase
			end

			// pair 2/3 only serves port2
			if (slot == slot_read1 && rd_arm1 && rd_port1 == port_req) begin
				port2_q   <= sd_din;
				port2_ack <= port2_req;
			end
		end
	end

endmodule

//--- hw/sdram_sequencer.sv
// fixed slot plan with no run-time timing; refresh only fits in slot 1 when port2 and slot 0 are idle
`timescale 1ns/1ps

module sdram_sequencer (
	input  logic                 clk,
	input  logic                 init_n,
	input  logic [1:0]           next_port0,
	input  logic [24:1]          next_addr0,
	input  logic [1:0]           next_port1,
	input  logic [24:1]          next_addr1,
	input  logic                 port1_we,
	input  logic [1:0]           port1_ds,
	input  logic [15:0]          port1_d,
	input  logic                 port2_we,
	input  logic [1:0]           port2_ds,
	input  logic [15:0]          port2_d,
	output logic                 take0,
	output logic                 take1,
	output logic                 refresh_busy,
	output logic [2:0]           slot,
	output logic                 rd_arm0,
	output logic [1:0]           rd_port0,
	output logic                 rd_arm1,
	output logic [1:0]           rd_port1,
	output logic                 wr_done0,
	output logic                 wr_done1,
	output logic [3:0]           cmd,
	output sdram_pkg::sdram_a_t  sd_a,
	output logic [1:0]           sd_ba,
	output logic [1:0]           dqm,
	output logic [15:0]          dq_out,
	output logic                 dq_oe
);
	import sdram_pkg::*;

	logic [4:0]  countdown;     // power-up slots left
	logic        init;          // power-up in progress
	logic [10:0] refresh_cnt;
	logic        need_refresh;

	logic        we_latch0;     // slot 0 holds a write
	logic        we_latch1;
	logic [1:0]  ba_latch0;
	logic [1:0]  ba_latch1;
	logic [8:0]  col_latch0;
	logic [8:0]  col_latch1;
	logic [1:0]  ds0;
	logic [1:0]  ds1;
	logic [15:0] din0;
	logic [15:0] din1;

	assign need_refresh = (refresh_cnt >= refresh_period);

	assign take0 = !init && (slot == slot_ras0);
	assign take1 = !init && (slot == slot_ras1);

	// write done in the same cycle as its CAS is issued
	assign wr_done0 = (slot == slot_cas0) && we_latch0;
	assign wr_done1 = (slot == slot_cas1) && we_latch1;

	// ----------------------------------------
	// slot counter, power-up, commands
	// ----------------------------------------
	always_ff @(posedge clk or negedge init_n) begin
		if (!init_n) begin
			slot         <= slot_ras0;
			countdown    <= init_count;
			init         <= 1'b1;
			refresh_cnt  <= '0;
			refresh_busy <= 1'b0;
			cmd          <= cmd_nop;
			dqm          <= 2'b11;
			dq_oe        <= 1'b0;
			rd_arm0      <= 1'b0;
			rd_arm1      <= 1'b0;
			we_latch0    <= 1'b0;
			we_latch1    <= 1'b0;
			rd_port0     <= port_none;
			rd_port1     <= port_none;
		end else begin
			slot <= (slot == slot_last) ? slot_ras0 : slot + 3'd1;
			if (slot == slot_last && countdown != 5'd0)
				countdown <= countdown - 5'd1;
			init <= (countdown != 5'd0);

			cmd   <= cmd_nop;  // idle unless a slot says otherwise
			dqm   <= 2'b11;
			dq_oe <= 1'b0;
			if (!need_refresh)
				refresh_cnt <= refresh_cnt + 11'd1;  // saturates at the period

			if (init) begin
				if (slot == slot_ras0) begin
					case (countdown)
						init_precharge:                 cmd <= cmd_precharge;
						init_refresh_a, init_refresh_b: cmd <= cmd_refresh;
						init_load_mode:                 cmd <= cmd_load_mode;
						default: ;
					endcase
				end
			end else begin
				// bank pair 0/1 ras
				if (slot == slot_ras0) begin
					rd_port0  <= next_port0;
					rd_arm0   <= 1'b0;
					we_latch0 <= 1'b0;
					if (next_port0 != port_none) begin
						cmd <= cmd_active;
						if (next_port0 == port_req) begin
							rd_arm0   <= !port1_we;
							we_latch0 <= port1_we;
						end else begin
							rd_arm0 <= 1'b1;  // fetches only read
						end
					end
				end

				// bank pair 2/3 ras, or refresh in its place
				if (slot == slot_ras1) begin
					refresh_busy <= 1'b0;
					rd_port1     <= next_port1;
					rd_arm1      <= 1'b0;
					we_latch1    <= 1'b0;
					if (next_port1 != port_none) begin
						cmd       <= cmd_active;
						rd_arm1   <= !port2_we;
						we_latch1 <= port2_we;
					end else if (need_refresh && !we_latch0 && !rd_arm0) begin
						cmd          <= cmd_refresh;
						refresh_busy <= 1'b1;  // keeps the next slot 0 empty
						refresh_cnt  <= '0;
					end
				end

				// cas, auto precharge
				if (slot == slot_cas0 && (we_latch0 || rd_arm0)) begin
					cmd   <= we_latch0 ? cmd_write : cmd_read;
					dqm   <= ~ds0;
					dq_oe <= we_latch0;
				end
				if (slot == slot_cas1 && (we_latch1 || rd_arm1)) begin
					cmd   <= we_latch1 ? cmd_write : cmd_read;
					dqm   <= ~ds1;
					dq_oe <= we_latch1;
				end
			end
		end
	end

	// ----------------------------------------
	// address, bank and write data
	// ----------------------------------------
	always_ff @(posedge clk) begin
		if (init) begin
			if (slot == slot_ras0) begin
				if (countdown == init_precharge)
					sd_a.col.auto_pre <= 1'b1;  // a10 selects all banks
				if (countdown == init_load_mode) begin
					sd_a.mode <= mode_word;
					sd_ba     <= 2'b00;
				end
			end
		end else begin
			if (slot == slot_ras0 && next_port0 != port_none) begin
				sd_a.row   <= next_addr0[22:10];
				sd_ba      <= next_addr0[24:23];
				ba_latch0  <= next_addr0[24:23];
				col_latch0 <= next_addr0[9:1];
				if (next_port0 == port_req) begin
					ds0  <= port1_ds;
					din0 <= port1_d;
				end else begin
					ds0 <= 2'b11;  // full word for fetches
				end
			end
			if (slot == slot_ras1 && next_port1 != port_none) begin
				sd_a.row   <= next_addr1[22:10];
				sd_ba      <= next_addr1[24:23];
				ba_latch1  <= next_addr1[24:23];
				col_latch1 <= next_addr1[9:1];
				ds1        <= port2_ds;
				din1       <= port2_d;
			end
			if (slot == slot_cas0 && (we_latch0 || rd_arm0)) begin
				sd_a.col <= '{spare_hi: 2'b00, auto_pre: 1'b1, spare_lo: 1'b0,
					column: col_latch0};
				sd_ba    <= ba_latch0;
				dq_out   <= din0;  // only driven out for writes
			end
			if (slot == slot_cas1 && (we_latch1 || rd_arm1)) begin
				sd_a.col <= '{spare_hi: 2'b00, auto_pre: 1'b1, spare_lo: 1'b0,
					column: col_latch1};
				sd_ba    <= ba_latch1;
				dq_out   <= din1;
			end
		end
	end

	// refresh on the pins only when the slot-0 pick four cycles back took nothing
	a_refresh_idle: assert property (@(posedge clk) disable iff (!init_n)
		(cmd == cmd_refresh && !init) |-> !$past(take0 && next_port0 != port_none, 4));

	// while refresh runs, port_select hands slot 0 nothing
	a_refresh_block: assert property (@(posedge clk) disable iff (!init_n)
		(take0 && refresh_busy) |=> !(we_latch0 || rd_arm0));

	// bus only driven in the cycle a write CAS is on the pins
	a_dq_write: assert property (@(posedge clk) disable iff (!init_n)
		dq_oe |-> (cmd == cmd_write) && $past(slot == slot_cas0 || slot == slot_cas1));

endmodule

//--- hw/port_select.sv
// fetch ports reach banks 0/1 only; no request may toggle again before its ack comes back
`timescale 1ns/1ps

module port_select (
	input  logic        clk,
	input  logic        init_n,
	input  logic        port1_req,
	input  logic [23:1] port1_a,
	input  logic [15:1] cpu1_addr,
	input  logic [15:1] cpu2_addr,
	input  logic        port2_req,
	input  logic [23:1] port2_a,
	input  logic        refresh_busy,   // slot-0 pick is held off
	input  logic        take0,          // sequencer accepted next_port0
	input  logic        take1,          // sequencer accepted next_port1
	output logic [1:0]  next_port0,
	output logic [24:1] next_addr0,
	output logic [1:0]  next_port1,
	output logic [24:1] next_addr1
);
	import sdram_pkg::*;

	logic        port1_state;  // toggles follow req once taken
	logic        port2_state;
	logic [15:1] last_cpu1;    // last fetch address served
	logic [15:1] last_cpu2;

	// ----------------------------------------
	// slot 0 pick, port1 > cpu1 > cpu2
	// ----------------------------------------
	always_comb begin
		next_port0 = port_none;
		next_addr0 = '0;
		if (!refresh_busy) begin
			if (port1_req != port1_state) begin
				next_port0 = port_req;
				next_addr0 = {1'b0, port1_a};       // bank 0/1
			end else if (cpu1_addr != last_cpu1) begin
				next_port0 = port_cpu1;
				next_addr0 = {9'd0, cpu1_addr};     // bank 0, low rows
			end else if (cpu2_addr != last_cpu2) begin
				next_port0 = port_cpu2;
				next_addr0 = {9'd0, cpu2_addr};
			end
		end
	end

	// slot 1 only ever serves port2, bank 2/3
	always_comb begin
		next_addr1 = {1'b1, port2_a};
		if (port2_req != port2_state)
			next_port1 = port_req;
		else
			next_port1 = port_none;
	end

	// ----------------------------------------
	// bookkeeping on take
	// ----------------------------------------
	always_ff @(posedge clk or negedge init_n) begin
		if (!init_n) begin
			port1_state <= 1'b0;
			port2_state <= 1'b0;
			last_cpu1   <= '0;
			last_cpu2   <= '0;
		end else begin
			if (take0) begin
				case (next_port0)
					port_req:  port1_state <= port1_req;  // request is now in flight
					port_cpu1: last_cpu1   <= cpu1_addr;
					port_cpu2: last_cpu2   <= cpu2_addr;
					default: ;
				endcase
			end
			if (take1 && next_port1 == port_req)
				port2_state <= port2_req;
		end
	end

	// the two slots are three cycles apart, never on the same edge
	a_take_apart: assert property (@(posedge clk) disable iff (!init_n)
		!(take0 && take1));

endmodule

//--- hw/sdram_pkg.sv
// fixed six-cycle slot timing for one x16 chip at CL2 with single-word access, refresh sized for ~108 MHz
package sdram_pkg;

	// ----------------------------------------
	// slot positions
	// ----------------------------------------
	localparam logic [2:0] slot_last  = 3'd5;  // counter wraps after this
	localparam logic [2:0] slot_ras0  = 3'd0;  // ACTIVE for bank pair 0/1
	localparam logic [2:0] slot_ras1  = 3'd3;  // ACTIVE for bank pair 2/3, tRRD after ras0
	localparam logic [2:0] slot_cas0  = 3'd2;  // tRCD of two cycles
	localparam logic [2:0] slot_cas1  = 3'd5;
	localparam logic [2:0] slot_read0 = 3'd0;  // registered data of pair 0/1 lands here
	localparam logic [2:0] slot_read1 = 3'd3;

	// chip commands, {ncs, nras, ncas, nwe}
	localparam logic [3:0] cmd_nop       = 4'b0111;
	localparam logic [3:0] cmd_active    = 4'b0011;
	localparam logic [3:0] cmd_read      = 4'b0101;
	localparam logic [3:0] cmd_write     = 4'b0100;
	localparam logic [3:0] cmd_precharge = 4'b0010;
	localparam logic [3:0] cmd_refresh   = 4'b0001;
	localparam logic [3:0] cmd_load_mode = 4'b0000;

	// who owns a slot
	localparam logic [1:0] port_none = 2'd0;
	localparam logic [1:0] port_cpu1 = 2'd1;
	localparam logic [1:0] port_cpu2 = 2'd2;
	localparam logic [1:0] port_req  = 2'd3;

	// burst 1, sequential, CL2, standard op, single-word writes
	localparam logic [12:0] mode_word = 13'b000_1_00_010_0_000;

	// 64 ms / 8192 rows at ~108 MHz
	localparam logic [10:0] refresh_period = 11'd842;

	// ----------------------------------------
	// power-up countdown, in slots
	// ----------------------------------------
	localparam logic [4:0] init_count     = 5'd31;
	localparam logic [4:0] init_precharge = 5'd15;
	localparam logic [4:0] init_refresh_a = 5'd10;
	localparam logic [4:0] init_refresh_b = 5'd8;
	localparam logic [4:0] init_load_mode = 5'd2;

	// chip address word, seen as row, column or mode register
	typedef union packed {
		logic [12:0] row;
		struct packed {
			logic [1:0] spare_hi;
			logic       auto_pre;   // a10
			logic       spare_lo;
			logic [8:0] column;
		} col;
		struct packed {
			logic [2:0] reserved;
			logic       wb_mode;    // 1 = single-word writes
			logic [1:0] op_mode;
			logic [2:0] cas_lat;
			logic       access;     // 0 = sequential
			logic [2:0] burst_len;
		} mode;
	} sdram_a_t;

endpackage
